// File: logic/sd_dat_config.svh
////////////////////////////////////////////////////////////
// Width and frame constants for the 4-bit DAT path
// Block sizes must be a whole number of buffer words
// Nibbles per word must be a power of two
////////////////////////////////////////////////////////////
`ifndef SD_DAT_CONFIG_SVH
`define SD_DAT_CONFIG_SVH

`define FIFO_WIDTH      32       // Buffer word, eight nibbles
`define BLOCK_SZ_WIDTH  10       // Blocks up to 512 bytes
`define BLOCK_CNT_WIDTH 8
`define CRC_NIBBLES     2        // Placeholders only

// Frame layout
`define WORD_NIBBLES    (`FIFO_WIDTH / 4)
`define WORD_BYTES      (`FIFO_WIDTH / 8)
`define START_NIBBLE    4'h0
`define CRC_FILL        4'h0
`define END_NIBBLE      4'hF

`endif

// File: logic/sd_dat_pkg.sv
////////////////////////////////////////////////////////////
// Types shared by the DAT controller and both block engines
////////////////////////////////////////////////////////////
`include "sd_dat_config.svh"

package sd_dat_pkg;

   typedef logic [3:0]                       nibble_t;     // One DAT bus value
   typedef logic [`FIFO_WIDTH-1:0]           fifo_word_t;
   typedef logic [`BLOCK_SZ_WIDTH-1:0]       blk_sz_t;     // Bytes
   typedef logic [`BLOCK_CNT_WIDTH-1:0]      blk_cnt_t;
   typedef logic [$clog2(`WORD_NIBBLES)-1:0] nib_idx_t;    // Nibble slot in a word

   localparam nib_idx_t LAST_NIB = nib_idx_t'(`WORD_NIBBLES - 1);

   // State encodings
   typedef enum logic [2:0] {
      WR_IDLE, WR_START, WR_DATA, WR_CRC, WR_END
   } wr_state_e;

   typedef enum logic [1:0] {
      RD_IDLE, RD_WAIT_START, RD_DATA, RD_WAIT_END
   } rd_state_e;

   typedef enum logic [1:0] {
      CTRL_IDLE, CTRL_WRITE_BLK, CTRL_READ_BLK, CTRL_GAP
   } ctrl_state_e;

endpackage

// File: logic/dat_blk_if.sv
////////////////////////////////////////////////////////////
// Block handshake between the transfer controller and one engine
// start is only raised while active is low
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

interface dat_blk_if;
   import sd_dat_pkg::*;

   logic    start;       // One cycle pulse
   blk_sz_t block_sz;    // Stable while active
   logic    active;      // Cycle after start up to block end
   logic    blk_done;    // One cycle pulse at block end

   modport ctrl (
      output start,
      output block_sz,
      input  active,
      input  blk_done
   );

   modport engine (
      input  start,
      input  block_sz,
      output active,
      output blk_done
   );

endinterface

// File: logic/dat_xfer_ctrl.sv
////////////////////////////////////////////////////////////
// Sequences multi-block transfers across the two block engines
// Request flags are sampled one cycle before they take effect
// block_cnt of zero with multiple set is not supported
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module dat_xfer_ctrl (
   input  logic                 sd_clk,
   input  logic                 rst_L,
   input  logic                 write_req,
   input  logic                 read_req,
   input  logic                 multiple,
   input  sd_dat_pkg::blk_sz_t  block_sz,
   input  sd_dat_pkg::blk_cnt_t block_cnt,
   input  logic                 dat0,
   input  logic                 dat_oe,
   input  logic                 tx_valid,
   dat_blk_if.ctrl              wr_blk,
   dat_blk_if.ctrl              rd_blk,
   output logic                 busy,
   output logic                 tf_finished
);
   import sd_dat_pkg::*;

   ctrl_state_e state;
   logic        write_q;
   logic        read_q;
   logic        multiple_q;
   logic        xfer_wr;      // Direction of the running transfer
   blk_cnt_t    blks_left;
   blk_sz_t     sz_q;
   logic        card_busy;
   logic        wr_go;
   logic        blk_done;

   assign card_busy = !dat0 && !dat_oe;     // Card pulls DAT0 low while busy
   assign wr_go     = tx_valid && !card_busy;
   assign blk_done  = xfer_wr ? wr_blk.blk_done : rd_blk.blk_done;

   assign wr_blk.block_sz = sz_q;
   assign rd_blk.block_sz = sz_q;

   always_ff @(posedge sd_clk) begin
      if (!rst_L) begin
         state        <= CTRL_IDLE;
         write_q      <= 1'b0;
         read_q       <= 1'b0;
         multiple_q   <= 1'b0;
         xfer_wr      <= 1'b0;
         blks_left    <= '0;
         busy         <= 1'b0;
         tf_finished  <= 1'b0;
         wr_blk.start <= 1'b0;
         rd_blk.start <= 1'b0;
      end else begin
         write_q      <= write_req;
         read_q       <= read_req;
         multiple_q   <= multiple;
         wr_blk.start <= 1'b0;
         rd_blk.start <= 1'b0;
         tf_finished  <= 1'b0;
         case (state)
            CTRL_IDLE: begin
               if (write_q && !read_q && wr_go) begin
                  state        <= CTRL_WRITE_BLK;
                  xfer_wr      <= 1'b1;
                  wr_blk.start <= 1'b1;
                  busy         <= 1'b1;
                  blks_left    <= multiple_q ? block_cnt : blk_cnt_t'(1);
               end else if (read_q && !write_q) begin
                  state        <= CTRL_READ_BLK;
                  xfer_wr      <= 1'b0;
                  rd_blk.start <= 1'b1;
                  busy         <= 1'b1;
                  blks_left    <= multiple_q ? block_cnt : blk_cnt_t'(1);
               end
            end
            CTRL_WRITE_BLK, CTRL_READ_BLK: begin
               if (blk_done) begin
                  blks_left <= blks_left - 1'b1;
                  if (blks_left == blk_cnt_t'(1)) begin
                     state       <= CTRL_IDLE;   // Last block
                     busy        <= 1'b0;
                     tf_finished <= 1'b1;
                  end else begin
                     state <= CTRL_GAP;
                  end
               end
            end
            CTRL_GAP: begin
               if (!xfer_wr) begin
                  state        <= CTRL_READ_BLK;
                  rd_blk.start <= 1'b1;
               end else if (wr_go) begin
                  state        <= CTRL_WRITE_BLK;   // Next word ready, card idle
                  wr_blk.start <= 1'b1;
               end
            end
            default: state <= CTRL_IDLE;
         endcase
      end
   end

   // Block size latched per transfer
   always_ff @(posedge sd_clk) begin
      if (state == CTRL_IDLE)
         sz_q <= block_sz;
   end

   // The two engines never own the bus together
   a_one_engine: assert property (@(posedge sd_clk) disable iff (!rst_L)
      !(wr_blk.active && rd_blk.active))
      else $error("dat_xfer_ctrl: both engines active");

endmodule

// File: logic/dat_writer.sv
////////////////////////////////////////////////////////////
// Serializes one block of transmit words onto DAT[3:0]
// Frame is start nibble, payload MSN first, CRC fill, end nibble
// The first word is taken at start, each later one on the cycle after a pop
// Block latency is 2*block_sz + 5 cycles from start to blk_done
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "sd_dat_config.svh"

module dat_writer (
   input  logic                   sd_clk,
   input  logic                   rst_L,
   dat_blk_if.engine              blk,
   input  sd_dat_pkg::fifo_word_t tx_data,
   input  logic                   tx_valid,
   output logic                   tx_rd,
   output sd_dat_pkg::nibble_t    dat_out,
   output logic                   dat_oe
);
   import sd_dat_pkg::*;

   localparam int CRC_W = $clog2(`CRC_NIBBLES + 1);

   wr_state_e        state;
   fifo_word_t       word_q;        // Next nibble sits on top
   fifo_word_t       word_src;
   nib_idx_t         nib_idx;
   blk_sz_t          bytes_left;
   logic [CRC_W-1:0] crc_cnt;
   logic             shifting;

   assign blk.active = (state != WR_IDLE);

   // Payload nibble launched this cycle
   assign shifting = (state == WR_START || state == WR_DATA) && bytes_left != '0;

   // Word boundary in data state means a pop just happened, so take the fresh head
   assign word_src = (state == WR_DATA && nib_idx == '0) ? tx_data : word_q;

   assign tx_rd = shifting && nib_idx == LAST_NIB;   // Pop with last nibble of the word

   ////////////////////////////////////////////////////////////
   // Frame sequencing
   ////////////////////////////////////////////////////////////
   always_ff @(posedge sd_clk) begin
      if (!rst_L) begin
         state        <= WR_IDLE;
         dat_out      <= '0;
         dat_oe       <= 1'b0;
         nib_idx      <= '0;
         bytes_left   <= '0;
         crc_cnt      <= '0;
         blk.blk_done <= 1'b0;
      end else begin
         blk.blk_done <= 1'b0;
         case (state)
            WR_IDLE: begin
               if (blk.start) begin
                  state      <= WR_START;
                  dat_oe     <= 1'b1;
                  dat_out    <= `START_NIBBLE;
                  nib_idx    <= '0;
                  bytes_left <= blk.block_sz;
               end
            end
            WR_START, WR_DATA: begin
               if (shifting) begin
                  state   <= WR_DATA;
                  dat_out <= word_src[`FIFO_WIDTH-1 -: 4];
                  nib_idx <= nib_idx + 1'b1;   // Wraps at word end
                  if (nib_idx == LAST_NIB)
                     bytes_left <= bytes_left - blk_sz_t'(`WORD_BYTES);
               end else begin
                  state   <= WR_CRC;           // First CRC nibble goes out now
                  dat_out <= `CRC_FILL;
                  crc_cnt <= CRC_W'(`CRC_NIBBLES - 1);
               end
            end
            WR_CRC: begin
               if (crc_cnt == '0) begin
                  state   <= WR_END;
                  dat_out <= `END_NIBBLE;
               end else begin
                  dat_out <= `CRC_FILL;
                  crc_cnt <= crc_cnt - 1'b1;
               end
            end
            WR_END: begin
               state        <= WR_IDLE;   // Release the bus
               dat_oe       <= 1'b0;
               dat_out      <= '0;
               blk.blk_done <= 1'b1;
            end
            default: state <= WR_IDLE;
         endcase
      end
   end

   // Word shifter
   always_ff @(posedge sd_clk) begin
      if (state == WR_IDLE && blk.start)
         word_q <= tx_data;
      else if (shifting)
         word_q <= word_src << 4;
   end

   // Every pop inside a block expects a word waiting in the transmit buffer
   a_no_underrun: assert property (@(posedge sd_clk) disable iff (!rst_L)
      tx_rd |-> tx_valid)
      else $error("dat_writer: transmit buffer underrun");

endmodule

// File: logic/dat_reader.sv
////////////////////////////////////////////////////////////
// Gathers one block from DAT[3:0] into receive words
// Waits for the start nibble, then takes 2*block_sz nibbles MSN first
// CRC nibbles are skipped until the end nibble shows up
// The receive buffer takes every push, there is no stall
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "sd_dat_config.svh"

module dat_reader (
   input  logic                   sd_clk,
   input  logic                   rst_L,
   dat_blk_if.engine              blk,
   input  sd_dat_pkg::nibble_t    dat_in,
   output sd_dat_pkg::fifo_word_t rx_data,
   output logic                   rx_wr
);
   import sd_dat_pkg::*;

   rd_state_e state;
   nib_idx_t  nib_idx;
   blk_sz_t   bytes_left;

   assign blk.active = (state != RD_IDLE);

   ////////////////////////////////////////////////////////////
   // Block sequencing
   ////////////////////////////////////////////////////////////
   always_ff @(posedge sd_clk) begin
      if (!rst_L) begin
         state        <= RD_IDLE;
         nib_idx      <= '0;
         bytes_left   <= '0;
         rx_wr        <= 1'b0;
         blk.blk_done <= 1'b0;
      end else begin
         rx_wr        <= 1'b0;
         blk.blk_done <= 1'b0;
         case (state)
            RD_IDLE: begin
               if (blk.start) begin
                  state      <= RD_WAIT_START;
                  nib_idx    <= '0;
                  bytes_left <= blk.block_sz;
               end
            end
            RD_WAIT_START: begin
               if (dat_in == `START_NIBBLE)
                  state <= RD_DATA;   // Payload from next cycle
            end
            RD_DATA: begin
               nib_idx <= nib_idx + 1'b1;
               if (nib_idx == LAST_NIB) begin
                  rx_wr      <= 1'b1;   // Word complete in rx_data next cycle
                  bytes_left <= bytes_left - blk_sz_t'(`WORD_BYTES);
                  if (bytes_left == blk_sz_t'(`WORD_BYTES))
                     state <= RD_WAIT_END;
               end
            end
            RD_WAIT_END: begin
               // CRC nibbles pass through here unchecked
               if (dat_in == `END_NIBBLE) begin
                  state        <= RD_IDLE;
                  blk.blk_done <= 1'b1;
               end
            end
            default: state <= RD_IDLE;
         endcase
      end
   end

   // Shift register doubles as the receive word
   always_ff @(posedge sd_clk) begin
      if (state == RD_DATA)
         rx_data <= {rx_data[`FIFO_WIDTH-5:0], dat_in};
   end

   // Pushes only come from payload capture while bytes remain in the block
   a_rx_wr_window: assert property (@(posedge sd_clk) disable iff (!rst_L)
      rx_wr |-> $past(state == RD_DATA && bytes_left != '0))
      else $error("dat_reader: rx_wr outside data phase");

endmodule

// File: logic/sd_dat_phys.sv
////////////////////////////////////////////////////////////
// DAT line side of the SD host, 4-bit bus only
// Transmit buffer must be first-word-fall-through
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module sd_dat_phys (
   input  logic                   sd_clk,
   input  logic                   rst_L,
   // Transmit buffer
   input  sd_dat_pkg::fifo_word_t tx_data,
   input  logic                   tx_valid,
   output logic                   tx_rd,
   // Receive buffer
   output sd_dat_pkg::fifo_word_t rx_data,
   output logic                   rx_wr,
   // DAT bus
   input  sd_dat_pkg::nibble_t    dat_in,
   output sd_dat_pkg::nibble_t    dat_out,
   output logic                   dat_oe,
   // Requests
   input  logic                   write_req,
   input  logic                   read_req,
   input  logic                   multiple,
   input  sd_dat_pkg::blk_sz_t    block_sz,
   input  sd_dat_pkg::blk_cnt_t   block_cnt,
   // Status
   output logic                   busy,
   output logic                   tf_finished
);

   dat_blk_if wr_blk_if ();
   dat_blk_if rd_blk_if ();

   dat_xfer_ctrl ctrl_i (
      .sd_clk      (sd_clk),
      .rst_L       (rst_L),
      .write_req   (write_req),
      .read_req    (read_req),
      .multiple    (multiple),
      .block_sz    (block_sz),
      .block_cnt   (block_cnt),
      .dat0        (dat_in[0]),   // Card busy sense
      .dat_oe      (dat_oe),
      .tx_valid    (tx_valid),
      .wr_blk      (wr_blk_if.ctrl),
      .rd_blk      (rd_blk_if.ctrl),
      .busy        (busy),
      .tf_finished (tf_finished)
   );

   dat_writer writer_i (
      .sd_clk   (sd_clk),
      .rst_L    (rst_L),
      .blk      (wr_blk_if.engine),
      .tx_data  (tx_data),
      .tx_valid (tx_valid),
      .tx_rd    (tx_rd),
      .dat_out  (dat_out),
      .dat_oe   (dat_oe)
   );

   dat_reader reader_i (
      .sd_clk  (sd_clk),
      .rst_L   (rst_L),
      .blk     (rd_blk_if.engine),
      .dat_in  (dat_in),
      .rx_data (rx_data),
      .rx_wr   (rx_wr)
   );

endmodule

// File: testbench/tb_sd_dat_phys.sv
////////////////////////////////////////////////////////////
// Directed tests for the 4-bit DAT path, 16-byte blocks only
// Card model drives dat_in, transmit buffer is a queue model
////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`include "sd_dat_config.svh"

module tb_sd_dat_phys;
   import sd_dat_pkg::*;

   localparam int BLK_BYTES = 16;
   localparam int BLK_WORDS = BLK_BYTES / 4;

   logic       sd_clk;
   logic       rst_L;
   fifo_word_t tx_data = '0;
   logic       tx_valid = 1'b0;
   logic       tx_rd;
   fifo_word_t rx_data;
   logic       rx_wr;
   nibble_t    dat_in;
   nibble_t    dat_out;
   logic       dat_oe;
   logic       write_req;
   logic       read_req;
   logic       multiple;
   blk_sz_t    block_sz;
   blk_cnt_t   block_cnt;
   logic       busy;
   logic       tf_finished;

   fifo_word_t  tx_q[$];        // Transmit buffer contents
   fifo_word_t  exp_tx[$];      // Words expected on DAT
   fifo_word_t  exp_rx[$];      // Words expected on rx_data
   logic        tx_rd_seen = 1'b0;
   logic        busy_prev = 1'b0;
   logic [15:0] lfsr_q = 16'd56;
   int          err_cnt = 0;
   int          to_cnt = 0;
   int          tx_rd_cnt = 0;
   int          fin_cnt = 0;
   int          rx_cnt = 0;
   int          base_tx;
   int          base_fin;
   int          base_rx;

   sd_dat_phys dut_i (.*);

   initial begin
      sd_clk = 1'b0;
      forever #2 sd_clk = ~sd_clk;
   end

   initial begin
      #100000;
      $display("Watchdog expired, simulation did not complete");
      $display("SOME TESTS FAILED");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Buffer model and monitors
   ////////////////////////////////////////////////////////////
   always @(posedge sd_clk) begin
      if (tx_rd_seen && tx_q.size() != 0)
         void'(tx_q.pop_front());       // Word taken at the previous edge
      tx_valid <= (tx_q.size() != 0);
      tx_data  <= (tx_q.size() != 0) ? tx_q[0] : '0;
   end

   always @(negedge sd_clk) begin
      tx_rd_seen = rst_L && tx_rd;
      if (rst_L) begin
         if (tx_rd)
            tx_rd_cnt++;
         if (tf_finished) begin
            fin_cnt++;
            check_bit("busy_at_finish", 1'b0, busy);   // Falls with the pulse
         end
         if (busy_prev && !busy && !tf_finished) begin
            $display("busy dropped before tf_finished pulsed");
            err_cnt++;
         end
         if (rx_wr) begin
            rx_cnt++;
            if (exp_rx.size() == 0) begin
               $display("rx_wr pushed a word when none was expected");
               err_cnt++;
            end else begin
               check_word("read", exp_rx.pop_front(), rx_data);
            end
         end
      end
      busy_prev = rst_L && busy;
   end

   // Compare tasks
   task automatic check_nibble(input string test, input nibble_t exp, input nibble_t act);
      if (exp !== act) begin
         $display("** Error %s: expected %h, actual %h", test, exp, act);
         err_cnt++;
      end
   endtask

   task automatic check_word(input string test, input fifo_word_t exp, input fifo_word_t act);
      if (exp !== act) begin
         $display("** Error %s: expected %h, actual %h", test, exp, act);
         err_cnt++;
      end
   endtask

   task automatic check_bit(input string test, input logic exp, input logic act);
      if (exp !== act) begin
         $display("** Error %s: expected %b, actual %b", test, exp, act);
         err_cnt++;
      end
   endtask

   task automatic check_count(input string test, input int exp, input int act);
      if (exp != act) begin
         $display("** Error %s: expected %0d, actual %0d", test, exp, act);
         err_cnt++;
      end
   endtask

   // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_step(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic rand_word(output fifo_word_t w);
      w = '0;
      for (int i = 0; i < `FIFO_WIDTH; i++) begin
         lfsr_q = lfsr_step(lfsr_q);
         w = {w[`FIFO_WIDTH-2:0], lfsr_q[0]};
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////
   task automatic wait_for(input string test, input string sig, input int limit,
                           output logic ok);
      int n;
      n = 0;
      ok = 1'b0;
      while (!ok && n < limit) begin
         @(negedge sd_clk);
         if (sig == "dat_oe")
            ok = dat_oe;
         else if (sig == "busy")
            ok = busy;
         else
            ok = tf_finished;
         n++;
      end
      if (!ok) begin
         $display("%s: %s did not rise within %0d cycles", test, sig, limit);
         to_cnt++;
      end
   endtask

   task automatic snapshot();
      base_tx  = tx_rd_cnt;
      base_fin = fin_cnt;
      base_rx  = rx_cnt;
   endtask

   task automatic load_tx(input int n);
      fifo_word_t w;
      @(negedge sd_clk);
      for (int i = 0; i < n; i++) begin
         rand_word(w);
         tx_q.push_back(w);
         exp_tx.push_back(w);
      end
   endtask

   // Request stays up until the controller reports busy
   task automatic hold_until_busy(input string test);
      logic ok;
      wait_for(test, "busy", 200, ok);
      @(posedge sd_clk);
      write_req <= 1'b0;
      read_req  <= 1'b0;
   endtask

   // One frame: start, payload MSN first, CRC fill, end, then bus released
   task automatic check_frame(input string test);
      fifo_word_t w;
      logic       ok;
      wait_for(test, "dat_oe", 200, ok);
      if (ok) begin
         check_nibble(test, 4'h0, dat_out);
         for (int i = 0; i < BLK_WORDS; i++) begin
            w = exp_tx.pop_front();
            for (int n = 0; n < 8; n++) begin
               @(negedge sd_clk);
               check_bit(test, 1'b1, dat_oe);
               check_nibble(test, w[`FIFO_WIDTH-1-4*n -: 4], dat_out);
            end
         end
         repeat (2) begin
            @(negedge sd_clk);
            check_bit(test, 1'b1, dat_oe);
            check_nibble(test, 4'h0, dat_out);
         end
         @(negedge sd_clk);
         check_bit(test, 1'b1, dat_oe);
         check_nibble(test, 4'hF, dat_out);
         @(negedge sd_clk);
         check_bit(test, 1'b0, dat_oe);
      end
   endtask

   task automatic finish_check(input string test, input int pops);
      logic ok;
      wait_for(test, "tf_finished", 200, ok);
      repeat (5) @(posedge sd_clk);     // Room for a stray second pulse
      check_count({test, "_pops"}, pops, tx_rd_cnt - base_tx);
      check_count({test, "_finished"}, 1, fin_cnt - base_fin);
      check_bit({test, "_busy"}, 1'b0, busy);
   endtask

   // Card side of a read block, nibbles change on the rising edge
   task automatic card_send_block(input int idle);
      fifo_word_t w;
      repeat (idle) @(posedge sd_clk) dat_in <= 4'hF;
      @(posedge sd_clk) dat_in <= 4'h0;
      for (int i = 0; i < BLK_WORDS; i++) begin
         rand_word(w);
         exp_rx.push_back(w);
         for (int n = 0; n < 8; n++)
            @(posedge sd_clk) dat_in <= w[`FIFO_WIDTH-1-4*n -: 4];
      end
      repeat (2) @(posedge sd_clk) dat_in <= 4'h0;
      @(posedge sd_clk) dat_in <= 4'hF;
   endtask

   ////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////
   task automatic test_reset();
      @(negedge sd_clk);
      check_bit("reset_dat_oe", 1'b0, dat_oe);
      check_bit("reset_tx_rd", 1'b0, tx_rd);
      check_bit("reset_rx_wr", 1'b0, rx_wr);
      check_bit("reset_busy", 1'b0, busy);
      check_bit("reset_finished", 1'b0, tf_finished);
      check_nibble("reset_dat_out", 4'h0, dat_out);
   endtask

   task automatic test_write(input string test, input logic mult, input int cnt,
                             input int blocks);
      snapshot();
      load_tx(blocks * BLK_WORDS);
      @(posedge sd_clk);
      multiple  <= mult;
      block_cnt <= blk_cnt_t'(cnt);
      write_req <= 1'b1;
      hold_until_busy(test);
      for (int b = 0; b < blocks; b++)
         check_frame(test);
      finish_check(test, blocks * BLK_WORDS);
   endtask

   task automatic test_busy_card();
      snapshot();
      @(posedge sd_clk) dat_in <= 4'hE;     // DAT0 held low by the card
      load_tx(BLK_WORDS);
      @(posedge sd_clk);
      multiple  <= 1'b0;
      write_req <= 1'b1;
      repeat (50) begin
         @(negedge sd_clk);
         check_bit("busy_card_hold", 1'b0, dat_oe);
      end
      @(posedge sd_clk) dat_in <= 4'hF;
      hold_until_busy("busy_card");
      check_frame("busy_card");
      finish_check("busy_card", BLK_WORDS);
   endtask

   task automatic test_read();
      snapshot();
      @(posedge sd_clk);
      multiple  <= 1'b1;
      block_cnt <= blk_cnt_t'(2);
      read_req  <= 1'b1;
      hold_until_busy("read");
      card_send_block(4);
      card_send_block(6);
      finish_check("read", 0);
      check_count("read_words", 2 * BLK_WORDS, rx_cnt - base_rx);
      check_count("read_left", 0, exp_rx.size());
   endtask

   initial begin
      rst_L     = 1'b0;
      write_req = 1'b0;
      read_req  = 1'b0;
      multiple  = 1'b0;
      block_sz  = blk_sz_t'(BLK_BYTES);
      block_cnt = blk_cnt_t'(1);
      dat_in    = 4'hF;
      repeat (10) @(posedge sd_clk);
      rst_L <= 1'b1;
      test_reset();
      test_write("single_write", 1'b0, 1, 1);
      test_write("multi_write", 1'b1, 3, 3);
      test_busy_card();
      test_read();
      test_write("multiple_clear", 1'b0, 3, 1);   // block_cnt ignored
      $display("Check errors: %0d, timeouts: %0d", err_cnt, to_cnt);
      if (err_cnt == 0 && to_cnt == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// File: sd_dat_phys.f
+incdir+logic
logic/sd_dat_pkg.sv
logic/dat_blk_if.sv
logic/dat_xfer_ctrl.sv
logic/dat_writer.sv
logic/dat_reader.sv
logic/sd_dat_phys.sv
testbench/tb_sd_dat_phys.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_sd_dat_phys
FILELIST  := sd_dat_phys.f
BUILD     := obj_dir
LOG       := sim.log
FAIL_MSG  := SOME TESTS FAILED

.PHONY: help test build clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

test: build
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
